/* verilog/axi_rd_pkg.sv */
`default_nettype none

package axi_rd_pkg;

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int OFFSET_W   = 2;   // Byte select within a word
   localparam int LEN_W      = 8;
   localparam int AXLEN_W    = 8;
   localparam int MAX_BEATS  = 16;
   localparam int BOUNDARY_W = 12;  // 4 KB

   // Fixed AR fields
   localparam logic [2:0] AXSIZE_WORD  = 3'b010;
   localparam logic [1:0] AXBURST_INCR = 2'b01;
   localparam logic [3:0] AXCACHE_VAL  = 4'h2;   // Modifiable
   localparam logic [2:0] AXPROT_VAL   = 3'b010;

   typedef enum logic [1:0] {
      IDLE,
      CALC,
      ADDR,
      DATA
   } rd_state_t;

endpackage

`default_nettype wire

/* verilog/xfer_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface xfer_if;

   logic                             transfer_start;
   logic                             burst_start;
   logic [axi_rd_pkg::ADDR_W-1:0]    axaddr;
   logic [axi_rd_pkg::AXLEN_W-1:0]   axlen;
   logic                             last_transfer;

   modport ctrl (
      output transfer_start,
      output burst_start,
      input  axlen,
      input  last_transfer
   );

   modport calc (
      input  transfer_start,
      input  burst_start,
      output axaddr,
      output axlen,
      output last_transfer
   );

endinterface

`default_nettype wire

/* verilog/transfer_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module transfer_controller (
   input  wire                             clk_i,
   input  wire                             rst_i,
   input  wire [axi_rd_pkg::ADDR_W-1:0]    address_i,
   input  wire [axi_rd_pkg::LEN_W-1:0]     length_i,   // In bytes
   xfer_if.calc                            xfer
);

   // Wide enough for the word count of a whole 4 KB page
   typedef logic [axi_rd_pkg::BOUNDARY_W-axi_rd_pkg::OFFSET_W:0] beats_t;
   typedef logic [axi_rd_pkg::ADDR_W-1:0]                        addr_t;
   typedef logic [axi_rd_pkg::AXLEN_W-1:0]                       len_t;

   addr_t  addr_q;
   beats_t remaining_q;
   beats_t total_beats;
   beats_t bnd_beats;
   beats_t burst_beats;
   logic   last_q;
   int     span;

   // Offset plus length, rounded up to whole words
   assign span = int'(address_i[axi_rd_pkg::OFFSET_W-1:0]) + int'(length_i)
                 + (1 << axi_rd_pkg::OFFSET_W) - 1;
   assign total_beats = beats_t'(span >> axi_rd_pkg::OFFSET_W);

   // Words left before the next 4 KB boundary
   assign bnd_beats = beats_t'((1 << (axi_rd_pkg::BOUNDARY_W - axi_rd_pkg::OFFSET_W))
                      - int'(addr_q[axi_rd_pkg::BOUNDARY_W-1:axi_rd_pkg::OFFSET_W]));

   always_comb begin
      burst_beats = beats_t'(axi_rd_pkg::MAX_BEATS);
      if (remaining_q < burst_beats) begin
         burst_beats = remaining_q;
      end
      if (bnd_beats < burst_beats) begin
         burst_beats = bnd_beats;
      end
   end

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         addr_q      <= '0;
         remaining_q <= '0;
         last_q      <= 1'b0;
      end else if (xfer.transfer_start) begin
         addr_q      <= {address_i[axi_rd_pkg::ADDR_W-1:axi_rd_pkg::OFFSET_W],
                         {axi_rd_pkg::OFFSET_W{1'b0}}};
         remaining_q <= total_beats;
         last_q      <= 1'b0;
      end else if (xfer.burst_start) begin
         addr_q      <= addr_q + (addr_t'(burst_beats) << axi_rd_pkg::OFFSET_W);
         remaining_q <= remaining_q - burst_beats;
         last_q      <= (remaining_q == burst_beats);  // Burst in flight ends the request
      end
   end

   assign xfer.axaddr        = addr_q;
   assign xfer.axlen         = len_t'(burst_beats - beats_t'(1));
   assign xfer.last_transfer = last_q;

   a_axlen_max: assert property (@(posedge clk_i) disable iff (rst_i)
      xfer.burst_start |-> xfer.axlen < len_t'(axi_rd_pkg::MAX_BEATS));

   a_no_4k_cross: assert property (@(posedge clk_i) disable iff (rst_i)
      xfer.burst_start |->
         int'(addr_q[axi_rd_pkg::BOUNDARY_W-1:0])
         + ((int'(xfer.axlen) + 1) << axi_rd_pkg::OFFSET_W)
         <= (1 << axi_rd_pkg::BOUNDARY_W));

endmodule

`default_nettype wire

/* verilog/burst_align.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_align (
   input  wire                             clk_i,
   input  wire                             rst_i,
   input  wire                             start_i,
   input  wire [axi_rd_pkg::OFFSET_W-1:0]  offset_i,
   input  wire [axi_rd_pkg::LEN_W-1:0]     length_i,
   input  wire [axi_rd_pkg::DATA_W-1:0]    data_i,
   input  wire                             valid_i,
   input  wire                             burst_last_i,
   input  wire                             transfer_last_i,
   output logic [axi_rd_pkg::DATA_W-1:0]   data_o,
   output logic                            valid_o,
   output logic                            last_o,
   output logic                            empty_o
);

   typedef logic [axi_rd_pkg::LEN_W-1:0]  bytes_t;
   typedef logic [axi_rd_pkg::DATA_W-1:0] word_t;

   word_t                             held_q;
   word_t                             lo;
   word_t                             word;
   logic [2*axi_rd_pkg::DATA_W-1:0]   joined;
   logic [axi_rd_pkg::OFFSET_W-1:0]   off_q;
   bytes_t                            left_q;      // Bytes still owed to the client
   bytes_t                            take;
   bytes_t                            left_after;
   bytes_t                            first_room;
   logic                              first_q;
   logic                              flush_q;
   logic                              emit;

   // Aligned start or single first beat reads straight from the bus
   assign lo     = (valid_i && (first_q || off_q == '0)) ? data_i : held_q;
   assign joined = {data_i, lo};
   assign word   = joined[{off_q, 3'b000} +: axi_rd_pkg::DATA_W];

   assign first_room = bytes_t'((1 << axi_rd_pkg::OFFSET_W) - int'(off_q));
   assign take       = (left_q > bytes_t'(axi_rd_pkg::DATA_W / 8)) ?
                       bytes_t'(axi_rd_pkg::DATA_W / 8) : left_q;

   always_comb begin
      emit = flush_q;
      if (valid_i && left_q != '0) begin
         if (first_q && off_q != '0) begin
            emit = (left_q <= first_room);  // Whole request inside the first beat
         end else begin
            emit = 1'b1;
         end
      end
   end

   assign left_after = emit ? left_q - take : left_q;

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         off_q   <= '0;
         left_q  <= '0;
         first_q <= 1'b0;
         flush_q <= 1'b0;
         empty_o <= 1'b1;
         valid_o <= 1'b0;
         last_o  <= 1'b0;
      end else begin
         valid_o <= emit;
         last_o  <= emit && (left_after == '0);
         if (start_i) begin
            off_q   <= offset_i;
            left_q  <= length_i;
            first_q <= 1'b1;
            flush_q <= 1'b0;
            empty_o <= 1'b0;
         end else begin
            left_q <= left_after;
            if (valid_i) begin
               first_q <= 1'b0;
            end
            // Held remainder goes out after the final beat
            flush_q <= burst_last_i && transfer_last_i && (left_after != '0);
            if (valid_o && last_o) begin
               empty_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (valid_i) begin
         held_q <= data_i;
      end
      if (emit) begin
         data_o <= word;
      end
   end

   a_no_stray_beat: assert property (@(posedge clk_i) disable iff (rst_i)
      valid_i |-> !empty_o);

endmodule

`default_nettype wire

/* verilog/read_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module read_fsm (
   input  wire                              clk_i,
   input  wire                              rst_i,
   input  wire                              m_rvalid_i,
   input  wire                              align_empty_i,
   input  wire                              axi_arready_i,
   input  wire                              axi_rvalid_i,
   input  wire                              axi_rlast_i,
   xfer_if.ctrl                             xfer,
   output logic                             axi_arvalid_o,
   output logic                             axi_rready_o,
   output logic [axi_rd_pkg::AXLEN_W-1:0]   axi_arlen_o,
   output logic                             align_start_o
);

   axi_rd_pkg::rd_state_t state_q;

   logic accept;
   logic r_last;

   assign accept = (state_q == axi_rd_pkg::IDLE) && m_rvalid_i && align_empty_i;
   assign r_last = axi_rvalid_i && axi_rready_o && axi_rlast_i;

   assign axi_rready_o        = (state_q == axi_rd_pkg::DATA);
   assign xfer.transfer_start = accept;
   assign xfer.burst_start    = axi_arvalid_o && axi_arready_i;  // AR handshake
   assign align_start_o       = accept;

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         state_q       <= axi_rd_pkg::IDLE;
         axi_arvalid_o <= 1'b0;
         axi_arlen_o   <= '0;
      end else begin
         unique case (state_q)
            axi_rd_pkg::IDLE: begin
               if (accept) begin
                  state_q <= axi_rd_pkg::CALC;
               end
            end
            axi_rd_pkg::CALC: begin
               axi_arvalid_o <= 1'b1;
               axi_arlen_o   <= xfer.axlen;  // Counter settled since load or advance
               state_q       <= axi_rd_pkg::ADDR;
            end
            axi_rd_pkg::ADDR: begin
               if (axi_arready_i) begin
                  axi_arvalid_o <= 1'b0;
                  state_q       <= axi_rd_pkg::DATA;
               end
            end
            axi_rd_pkg::DATA: begin
               if (r_last) begin
                  state_q <= xfer.last_transfer ? axi_rd_pkg::IDLE : axi_rd_pkg::CALC;
               end
            end
            default: state_q <= axi_rd_pkg::IDLE;
         endcase
      end
   end

   a_arvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o);

endmodule

`default_nettype wire

/* verilog/simple_axi_read.sv */
`timescale 1ns/1ps
`default_nettype none

module simple_axi_read (
   input  wire                              clk_i,
   input  wire                              rst_i,

   // Client read port
   input  wire                              m_rvalid_i,
   input  wire [axi_rd_pkg::ADDR_W-1:0]     m_raddr_i,
   input  wire [axi_rd_pkg::LEN_W-1:0]      m_rlen_i,
   output logic                             m_rready_o,
   output logic [axi_rd_pkg::DATA_W-1:0]    m_rdata_o,
   output logic                             m_rlast_o,

   // AXI read master
   input  wire                              axi_arready_i,
   input  wire                              axi_rvalid_i,
   input  wire [axi_rd_pkg::DATA_W-1:0]     axi_rdata_i,
   input  wire                              axi_rlast_i,
   input  wire [1:0]                        axi_rresp_i,   // Not checked
   output logic                             axi_arvalid_o,
   output logic [axi_rd_pkg::ADDR_W-1:0]    axi_araddr_o,
   output logic [axi_rd_pkg::AXLEN_W-1:0]   axi_arlen_o,
   output logic [2:0]                       axi_arsize_o,
   output logic [1:0]                       axi_arburst_o,
   output logic [3:0]                       axi_arid_o,
   output logic                             axi_arlock_o,
   output logic [3:0]                       axi_arcache_o,
   output logic [2:0]                       axi_arprot_o,
   output logic [3:0]                       axi_arqos_o,
   output logic                             axi_rready_o
);

   logic align_start;
   logic align_empty;
   logic r_beat;
   logic r_burst_last;

   xfer_if xfer ();

   assign r_beat       = axi_rvalid_i && axi_rready_o;
   assign r_burst_last = r_beat && axi_rlast_i;

   assign axi_araddr_o  = xfer.axaddr;
   assign axi_arsize_o  = axi_rd_pkg::AXSIZE_WORD;
   assign axi_arburst_o = axi_rd_pkg::AXBURST_INCR;
   assign axi_arid_o    = '0;
   assign axi_arlock_o  = 1'b0;
   assign axi_arcache_o = axi_rd_pkg::AXCACHE_VAL;
   assign axi_arprot_o  = axi_rd_pkg::AXPROT_VAL;
   assign axi_arqos_o   = '0;

   read_fsm u_fsm (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .m_rvalid_i    (m_rvalid_i),
      .align_empty_i (align_empty),
      .axi_arready_i (axi_arready_i),
      .axi_rvalid_i  (axi_rvalid_i),
      .axi_rlast_i   (axi_rlast_i),
      .xfer          (xfer.ctrl),
      .axi_arvalid_o (axi_arvalid_o),
      .axi_rready_o  (axi_rready_o),
      .axi_arlen_o   (axi_arlen_o),
      .align_start_o (align_start)
   );

   transfer_controller u_ctrl (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .address_i (m_raddr_i),
      .length_i  (m_rlen_i),
      .xfer      (xfer.calc)
   );

   burst_align u_align (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .start_i         (align_start),
      .offset_i        (m_raddr_i[axi_rd_pkg::OFFSET_W-1:0]),
      .length_i        (m_rlen_i),
      .data_i          (axi_rdata_i),
      .valid_i         (r_beat),
      .burst_last_i    (r_burst_last),
      .transfer_last_i (xfer.last_transfer),
      .data_o          (m_rdata_o),
      .valid_o         (m_rready_o),
      .last_o          (m_rlast_o),
      .empty_o         (align_empty)
   );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
   input  wire         clk_i,
   input  wire         rst_i,
   input  wire         arvalid_i,
   input  wire [31:0]  araddr_i,
   input  wire [7:0]   arlen_i,
   input  wire         rready_i,
   output logic        arready_o,
   output logic        rvalid_o,
   output logic [31:0] rdata_o,
   output logic        rlast_o,
   output logic [1:0]  rresp_o
);

   logic [31:0] seed;
   logic [31:0] ar_addr_q;
   logic [7:0]  ar_len_q;
   logic        ar_taken;   // Handshakes seen at the last rising edge
   logic        r_taken;
   logic [31:0] beat_addr;
   int          beats_left;
   int          ar_wait;
   int          r_wait;

   function automatic logic [7:0] stored_byte(input logic [31:0] a);
      return 8'(a * 32'd7 + 32'd3);
   endfunction

   function automatic logic [31:0] word_at(input logic [31:0] a);
      return {stored_byte(a + 3), stored_byte(a + 2), stored_byte(a + 1), stored_byte(a)};
   endfunction

   // Stall of 0 to 3 cycles from the upper LCG bits
   function automatic int next_stall();
      seed = seed * 32'd1103515245 + 32'd12345;
      return int'(seed[17:16]);
   endfunction

   assign rresp_o = 2'b00;

   always @(posedge clk_i) begin
      ar_taken <= arvalid_i && arready_o;
      r_taken  <= rvalid_o && rready_i;
      if (arvalid_i && arready_o) begin
         ar_addr_q <= araddr_i;
         ar_len_q  <= arlen_i;
      end
   end

   initial begin
      seed       = 32'hb263;
      arready_o  = 1'b0;
      rvalid_o   = 1'b0;
      rlast_o    = 1'b0;
      rdata_o    = '0;
      beat_addr  = '0;
      beats_left = 0;
      ar_wait    = 0;
      r_wait     = 0;
      forever begin
         @(negedge clk_i);
         if (rst_i) begin
            arready_o  = 1'b0;
            rvalid_o   = 1'b0;
            rlast_o    = 1'b0;
            beats_left = 0;
         end else begin
            if (ar_taken) begin
               arready_o  = 1'b0;
               beat_addr  = ar_addr_q;
               beats_left = int'(ar_len_q) + 1;
               r_wait     = next_stall();
            end
            if (r_taken) begin
               rvalid_o   = 1'b0;
               rlast_o    = 1'b0;
               beat_addr  = beat_addr + 32'd4;
               beats_left = beats_left - 1;
            end
            if (arvalid_i && !arready_o) begin
               if (ar_wait == 0) begin
                  arready_o = 1'b1;
                  ar_wait   = next_stall();   // Used by the next AR
               end else begin
                  ar_wait = ar_wait - 1;
               end
            end
            if (beats_left != 0 && !rvalid_o) begin
               if (r_wait == 0) begin
                  rvalid_o = 1'b1;
                  rdata_o  = word_at(beat_addr);
                  rlast_o  = (beats_left == 1);
                  r_wait   = next_stall();
               end else begin
                  r_wait = r_wait - 1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* sim/tb_simple_axi_read.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_simple_axi_read;

   localparam int NUM_FIXED   = 10;
   localparam int NUM_RANDOM  = 20;
   localparam int NUM_REQ     = NUM_FIXED + NUM_RANDOM;
   localparam int RESET_CYC   = 16;
   localparam int CYCLE_LIMIT = NUM_REQ * 300 + RESET_CYC;

   logic        clk_i;
   logic        rst_i;
   logic        m_rvalid_i;
   logic [31:0] m_raddr_i;
   logic [7:0]  m_rlen_i;
   logic        m_rready_o;
   logic [31:0] m_rdata_o;
   logic        m_rlast_o;
   logic        axi_arready_i;
   logic        axi_rvalid_i;
   logic [31:0] axi_rdata_i;
   logic        axi_rlast_i;
   logic [1:0]  axi_rresp_i;
   logic        axi_arvalid_o;
   logic [31:0] axi_araddr_o;
   logic [7:0]  axi_arlen_o;
   logic [2:0]  axi_arsize_o;
   logic [1:0]  axi_arburst_o;
   logic [3:0]  axi_arid_o;
   logic        axi_arlock_o;
   logic [3:0]  axi_arcache_o;
   logic [2:0]  axi_arprot_o;
   logic [3:0]  axi_arqos_o;
   logic        axi_rready_o;

   logic [31:0] rand_state;
   logic [31:0] req_addr = '0;
   logic [7:0]  req_len = '0;
   logic [31:0] next_ar = '0;   // Where the next burst must start
   logic [31:0] exp_word;
   logic [31:0] exp_mask;
   logic        accept;
   logic        ar_hs;
   int          word_idx = 0;
   int          beat_sum = 0;
   int          nwords;
   int          exp_beats;
   int          error_count = 0;
   int          request_count = 0;
   int          burst_count = 0;
   int          word_count = 0;
   int          cycle_count = 0;

   tb_clock_gen #(.PERIOD_NS(100)) u_clk (.clk_o(clk_i));

   simple_axi_read dut (.*);

   axi_mem_model u_mem (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .arvalid_i (axi_arvalid_o),
      .araddr_i  (axi_araddr_o),
      .arlen_i   (axi_arlen_o),
      .rready_i  (axi_rready_o),
      .arready_o (axi_arready_i),
      .rvalid_o  (axi_rvalid_i),
      .rdata_o   (axi_rdata_i),
      .rlast_o   (axi_rlast_i),
      .rresp_o   (axi_rresp_i)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] x);
      return x * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [7:0] expected_byte(input logic [31:0] a);
      return 8'(a * 32'd7 + 32'd3);
   endfunction

   task automatic log_error(input string msg);
      error_count++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   // Request held until the last word and dropped on that falling edge
   task automatic issue_request(input logic [31:0] addr, input logic [7:0] len);
      @(negedge clk_i);
      m_raddr_i  = addr;
      m_rlen_i   = len;
      m_rvalid_i = 1'b1;
      do begin
         @(negedge clk_i);
      end while (!m_rlast_o);
      m_rvalid_i = 1'b0;
   endtask

   assign accept    = (dut.u_fsm.state_q == axi_rd_pkg::IDLE) && m_rvalid_i && dut.align_empty;
   assign ar_hs     = axi_arvalid_o && axi_arready_i;
   assign nwords    = (int'(req_len) + 3) / 4;
   assign exp_beats = (int'(req_addr[1:0]) + int'(req_len) + 3) / 4;

   // Bytes of the current word that lie inside the request
   always_comb begin
      exp_word = '0;
      exp_mask = '0;
      for (int b = 0; b < 4; b++) begin
         if (word_idx * 4 + b < int'(req_len)) begin
            exp_word[8*b +: 8] = expected_byte(req_addr + 32'(word_idx * 4 + b));
            exp_mask[8*b +: 8] = 8'hff;
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_count <= cycle_count + 1;
      if (accept) begin
         req_addr <= m_raddr_i;
         req_len  <= m_rlen_i;
         next_ar  <= {m_raddr_i[31:2], 2'b00};
         word_idx <= 0;
         beat_sum <= 0;
      end
      if (ar_hs) begin
         next_ar     <= axi_araddr_o + ((32'(axi_arlen_o) + 32'd1) << 2);
         beat_sum    <= beat_sum + int'(axi_arlen_o) + 1;
         burst_count <= burst_count + 1;
      end
      if (m_rready_o) begin
         word_idx   <= word_idx + 1;
         word_count <= word_count + 1;
      end
      if (m_rlast_o) begin
         request_count <= request_count + 1;
      end
   end

   a_reset_quiet: assert property (@(posedge clk_i)
      $fell(rst_i) |-> !axi_arvalid_o && !axi_rready_o && !m_rready_o && !m_rlast_o
                       && dut.u_fsm.state_q == axi_rd_pkg::IDLE && dut.align_empty)
      else log_error("control outputs not idle after reset");

   a_ar_fields: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_hs |-> axi_arsize_o == 3'b010 && axi_arburst_o == 2'b01 && axi_arid_o == 4'd0)
      else log_error("wrong ARSIZE, ARBURST or ARID");

   a_ar_fixed: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_hs |-> !axi_arlock_o && axi_arcache_o == 4'b0010 && axi_arqos_o == 4'd0
                && axi_arprot_o == axi_rd_pkg::AXPROT_VAL)
      else log_error("wrong ARLOCK, ARCACHE, ARPROT or ARQOS");

   a_ar_shape: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_hs |-> axi_arlen_o <= 8'd15 && axi_araddr_o[1:0] == 2'b00)
      else log_error("ARLEN over 15 or ARADDR not word aligned");

   a_ar_4k: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_hs |-> int'(axi_araddr_o[11:0]) + (int'(axi_arlen_o) + 1) * 4 <= 4096)
      else log_error("burst crosses a 4 KB boundary");

   a_ar_contiguous: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_hs |-> axi_araddr_o == next_ar)
      else log_error("burst does not start where the previous one ended");

   a_ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_arvalid_o && !axi_arready_i |=>
         axi_arvalid_o && $stable(axi_araddr_o) && $stable(axi_arlen_o))
      else log_error("AR channel changed before ARREADY");

   a_no_ar_in_data: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_rready_o |-> !axi_arvalid_o)
      else log_error("ARVALID while RREADY is high");

   a_accept_gap: assert property (@(posedge clk_i) disable iff (rst_i)
      accept |=> !axi_arvalid_o)
      else log_error("ARVALID one cycle after acceptance");

   a_accept_arvalid: assert property (@(posedge clk_i) disable iff (rst_i)
      $past(accept, 2) |-> axi_arvalid_o)
      else log_error("ARVALID not high two cycles after acceptance");

   a_word_data: assert property (@(posedge clk_i) disable iff (rst_i)
      m_rready_o |-> ((m_rdata_o ^ exp_word) & exp_mask) == 32'd0)
      else log_error($sformatf("word %0d data mismatch", $sampled(word_idx)));

   a_word_count: assert property (@(posedge clk_i) disable iff (rst_i)
      m_rready_o |-> word_idx < nwords)
      else log_error("more words than the request length allows");

   a_last_position: assert property (@(posedge clk_i) disable iff (rst_i)
      m_rready_o |-> m_rlast_o == (word_idx == nwords - 1))
      else log_error("last flag not on the final word");

   a_last_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
      m_rlast_o |-> m_rready_o)
      else log_error("last flag without a word strobe");

   a_beat_total: assert property (@(posedge clk_i) disable iff (rst_i)
      m_rlast_o |-> beat_sum == exp_beats)
      else log_error("burst lengths do not add up to the request");

   initial begin
      wait (cycle_count >= CYCLE_LIMIT);
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("test failed");
      $finish;
   end

   initial begin
      logic [31:0] addr;
      logic [7:0]  len;
      rst_i      = 1'b1;
      m_rvalid_i = 1'b0;
      m_raddr_i  = '0;
      m_rlen_i   = '0;
      rand_state = 32'hb263;
      repeat (RESET_CYC) @(negedge clk_i);
      rst_i = 1'b0;

      // Aligned, offsets 1 to 3, single bytes, long runs across 4 KB pages
      issue_request(32'h0000_1000, 8'd4);
      issue_request(32'h0000_2001, 8'd7);
      issue_request(32'h0000_3002, 8'd1);
      issue_request(32'h0000_4003, 8'd1);
      issue_request(32'h0000_4103, 8'd2);
      issue_request(32'h0000_0ff0, 8'd200);
      issue_request(32'h0000_1ffd, 8'd255);
      issue_request(32'h0001_0100, 8'd255);
      issue_request(32'h0000_5ffe, 8'd230);
      issue_request(32'h0000_6002, 8'd64);

      for (int i = 0; i < NUM_RANDOM; i++) begin
         rand_state = lcg_next(rand_state);
         addr = {12'h000, rand_state[31:12]};
         if (i % 2 == 0) begin
            addr[11:6] = 6'h3f;   // Near a page end
         end
         rand_state = lcg_next(rand_state);
         len = (rand_state[31:24] == 8'd0) ? 8'd1 : rand_state[31:24];
         issue_request(addr, len);
      end

      repeat (4) @(negedge clk_i);
      $display("Summary: %0d requests, %0d bursts, %0d words, %0d errors",
               request_count, burst_count, word_count, error_count);
      if (error_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
verilog/axi_rd_pkg.sv
verilog/xfer_if.sv
verilog/transfer_controller.sv
verilog/burst_align.sv
verilog/read_fsm.sv
verilog/simple_axi_read.sv
sim/tb_clock_gen.sv
sim/axi_mem_model.sv
sim/tb_simple_axi_read.sv

/* Bender.yml */
package:
  name: simple_axi_read

sources:
  - files:
      - verilog/axi_rd_pkg.sv
      - verilog/xfer_if.sv
      - verilog/transfer_controller.sv
      - verilog/burst_align.sv
      - verilog/read_fsm.sv
      - verilog/simple_axi_read.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/axi_mem_model.sv
      - sim/tb_simple_axi_read.sv
